// File: src/deparser_pkg.sv
package deparser_pkg;

    // action table entry
    localparam int N_ACTIONS = 5;
    localparam int ACTION_W = 16;
    localparam int ENTRY_W = N_ACTIONS * ACTION_W;

    // fields of one action
    localparam int ACT_VALID_BIT = 0;
    localparam int ACT_IDX_LSB = 1;
    localparam int ACT_IDX_W = 3;
    localparam int ACT_TYPE_LSB = 4;
    localparam int ACT_TYPE_W = 2;
    localparam int ACT_OFF_LSB = 6;
    localparam int ACT_OFF_W = 6;

    // table geometry, addressed from the first beat
    localparam int TABLE_ADDR_W = 4;
    localparam int TABLE_DEPTH = 16;
    localparam int TABLE_ADDR_LSB = 120;

    // phv layout
    localparam int PHV_W = 768;
    localparam int PHV_2B_BASE = 0;
    localparam int PHV_4B_BASE = 128;
    localparam int PHV_6B_BASE = 384;

    // container type codes, 0 means no write
    localparam logic [ACT_TYPE_W-1:0] TYPE_2B = 2'd1;
    localparam logic [ACT_TYPE_W-1:0] TYPE_4B = 2'd2;
    localparam logic [ACT_TYPE_W-1:0] TYPE_6B = 2'd3;

    localparam int MAX_FIELD_BYTES = 6;
    localparam int FIELD_VALUE_W = MAX_FIELD_BYTES * 8;
    localparam int FIELD_BYTES_W = $clog2(MAX_FIELD_BYTES + 1);

    // control header
    localparam int CTRL_MODID_LSB = 368;
    localparam int CTRL_MODID_W = 3;
    localparam int CTRL_FLAG_LSB = 320;
    localparam int CTRL_FLAG_W = 16;
    localparam int CTRL_INDEX_LSB = 384;
    localparam logic [CTRL_FLAG_W-1:0] CTRL_FLAG = 16'hf2f1;

endpackage

// File: src/action_table.sv
`timescale 1ns/1ps

module action_table #(
    parameter int DATA_WIDTH = 512,
    parameter int DEPARSER_ID = 5
) (
    input  logic                                 clk,
    input  logic                                 aresetn,
    input  logic [DATA_WIDTH-1:0]                c_s_axis_tdata,
    input  logic                                 c_s_axis_tvalid,
    input  logic                                 c_s_axis_tlast,
    input  logic [deparser_pkg::TABLE_ADDR_W-1:0] lookup_addr,
    input  logic                                 lookup_en,
    output logic [deparser_pkg::ENTRY_W-1:0]     action_entry
);
    import deparser_pkg::*;

    localparam logic C_IDLE = 1'b0;
    localparam logic C_WRITE = 1'b1;

    logic                    c_state;
    logic                    hdr_hit;
    logic                    tbl_wr_en;
    logic [TABLE_ADDR_W-1:0] wr_idx;
    logic [ENTRY_W-1:0]      entry_swapped;
    logic [ENTRY_W-1:0]      tbl_mem [TABLE_DEPTH];

    // header beat addressed to this deparser
    assign hdr_hit = c_s_axis_tvalid
        && c_s_axis_tdata[CTRL_MODID_LSB +: CTRL_MODID_W] == CTRL_MODID_W'(DEPARSER_ID)
        && c_s_axis_tdata[CTRL_FLAG_LSB +: CTRL_FLAG_W] == CTRL_FLAG;

    assign tbl_wr_en = (c_state == C_WRITE) && c_s_axis_tvalid;

    // byte 2k is the high byte of action k
    always_comb begin
        for (int k = 0; k < N_ACTIONS; k++) begin
            entry_swapped[k*ACTION_W +: ACTION_W] = {c_s_axis_tdata[k*ACTION_W +: 8],
                                                     c_s_axis_tdata[k*ACTION_W+8 +: 8]};
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            c_state <= C_IDLE;
            wr_idx <= '0;
        end else begin
            case (c_state)
                C_IDLE: begin
                    if (hdr_hit) begin
                        wr_idx <= c_s_axis_tdata[CTRL_INDEX_LSB +: TABLE_ADDR_W];
                        // a header with tlast carries no entries
                        if (!c_s_axis_tlast) begin
                            c_state <= C_WRITE;
                        end
                    end
                end
                C_WRITE: begin
                    if (c_s_axis_tvalid) begin
                        wr_idx <= wr_idx + 1'b1;
                        if (c_s_axis_tlast) begin
                            c_state <= C_IDLE;
                        end
                    end
                end
                default: c_state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_wr_en) begin
            tbl_mem[wr_idx] <= entry_swapped;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            action_entry <= tbl_mem[lookup_addr];
        end
    end

endmodule

// File: src/container_fetch.sv
`timescale 1ns/1ps

module container_fetch (
    input  logic                                    clk,
    input  logic                                    aresetn,
    input  logic [deparser_pkg::PHV_W-1:0]          phv,
    input  logic [deparser_pkg::ACTION_W-1:0]       action,
    input  logic                                    fetch_en,
    output logic [deparser_pkg::FIELD_VALUE_W-1:0]  field_value,
    output logic [deparser_pkg::FIELD_BYTES_W-1:0]  field_bytes,
    output logic [deparser_pkg::ACT_OFF_W-1:0]      field_offset
);
    import deparser_pkg::*;

    logic                     act_valid;
    logic [ACT_IDX_W-1:0]     act_idx;
    logic [ACT_TYPE_W-1:0]    act_type;
    logic [FIELD_VALUE_W-1:0] sel_value;
    logic [FIELD_BYTES_W-1:0] sel_bytes;

    assign act_valid = action[ACT_VALID_BIT];
    assign act_idx = action[ACT_IDX_LSB +: ACT_IDX_W];
    assign act_type = action[ACT_TYPE_LSB +: ACT_TYPE_W];

    // container value left-aligned with its msb in the top byte
    always_comb begin
        sel_value = '0;
        sel_bytes = '0;
        if (act_valid) begin
            case (act_type)
                TYPE_2B: begin
                    sel_value = {phv[PHV_2B_BASE + act_idx*16 +: 16], 32'd0};
                    sel_bytes = 3'd2;
                end
                TYPE_4B: begin
                    sel_value = {phv[PHV_4B_BASE + act_idx*32 +: 32], 16'd0};
                    sel_bytes = 3'd4;
                end
                TYPE_6B: begin
                    sel_value = phv[PHV_6B_BASE + act_idx*48 +: 48];
                    sel_bytes = 3'd6;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            field_bytes <= '0;
        end else if (fetch_en) begin
            field_bytes <= sel_bytes;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            field_value <= sel_value;
            field_offset <= action[ACT_OFF_LSB +: ACT_OFF_W];
        end
    end

endmodule

// File: src/deparse_fsm.sv
`timescale 1ns/1ps

module deparse_fsm #(
    parameter int DATA_WIDTH = 512
) (
    input  logic                                    clk,
    input  logic                                    aresetn,

    input  logic [DATA_WIDTH-1:0]                   pkt_fifo_tdata,
    input  logic [DATA_WIDTH/8-1:0]                 pkt_fifo_tkeep,
    input  logic                                    pkt_fifo_tlast,
    input  logic                                    pkt_fifo_empty,
    output logic                                    pkt_fifo_rd_en,

    input  logic [deparser_pkg::PHV_W-1:0]          phv_fifo_out,
    input  logic                                    phv_fifo_empty,
    output logic                                    phv_fifo_rd_en,

    input  logic [deparser_pkg::FIELD_VALUE_W-1:0]  field_value [deparser_pkg::N_ACTIONS],
    input  logic [deparser_pkg::FIELD_BYTES_W-1:0]  field_bytes [deparser_pkg::N_ACTIONS],
    input  logic [deparser_pkg::ACT_OFF_W-1:0]      field_offset [deparser_pkg::N_ACTIONS],

    output logic [deparser_pkg::TABLE_ADDR_W-1:0]   lookup_addr,
    output logic                                    lookup_en,
    output logic [deparser_pkg::PHV_W-1:0]          phv_stored,
    output logic                                    fetch_en,

    output logic [DATA_WIDTH-1:0]                   depar_out_tdata,
    output logic [DATA_WIDTH/8-1:0]                 depar_out_tkeep,
    output logic                                    depar_out_tlast,
    output logic                                    depar_out_tvalid,
    input  logic                                    depar_out_tready
);
    import deparser_pkg::*;

    localparam int BEAT_BYTES = DATA_WIDTH / 8;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_FETCH = 3'd2;
    localparam logic [2:0] S_APPLY = 3'd3;
    localparam logic [2:0] S_SEND = 3'd4;

    logic [2:0]            state;
    logic                  start;
    logic                  first_pop;
    logic                  payload_pop;
    logic                  out_fire;
    logic [DATA_WIDTH-1:0] beat_q;
    logic [BEAT_BYTES-1:0] keep_q;
    logic                  last_q;
    logic [DATA_WIDTH-1:0] beat_applied;

    assign start = (state == S_IDLE) && !pkt_fifo_empty && !phv_fifo_empty;
    assign out_fire = depar_out_tvalid && depar_out_tready;

    // next payload beat enters the output register once the slot frees up
    assign payload_pop = (state == S_SEND) && !pkt_fifo_empty
        && !(depar_out_tvalid && depar_out_tlast)
        && (!depar_out_tvalid || depar_out_tready);

    assign pkt_fifo_rd_en = first_pop || payload_pop;

    // actions in order 0..4, later ones win on overlap
    always_comb begin
        int pos;
        beat_applied = beat_q;
        for (int a = 0; a < N_ACTIONS; a++) begin
            for (int j = 0; j < MAX_FIELD_BYTES; j++) begin
                pos = int'(field_offset[a]) + j;
                if (j < int'(field_bytes[a]) && pos < BEAT_BYTES) begin
                    beat_applied[pos*8 +: 8] = field_value[a][(MAX_FIELD_BYTES-1-j)*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state <= S_IDLE;
            first_pop <= 1'b0;
            lookup_en <= 1'b0;
            fetch_en <= 1'b0;
            phv_fifo_rd_en <= 1'b0;
            depar_out_tvalid <= 1'b0;
            depar_out_tlast <= 1'b0;
        end else begin
            first_pop <= 1'b0;
            lookup_en <= 1'b0;
            fetch_en <= 1'b0;
            phv_fifo_rd_en <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        first_pop <= 1'b1;
                        lookup_en <= 1'b1;
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    fetch_en <= 1'b1;
                    state <= S_FETCH;
                end
                S_FETCH: state <= S_APPLY;
                S_APPLY: begin
                    phv_fifo_rd_en <= 1'b1;
                    depar_out_tvalid <= 1'b1;
                    depar_out_tlast <= last_q;
                    state <= S_SEND;
                end
                S_SEND: begin
                    if (out_fire && depar_out_tlast) begin
                        depar_out_tvalid <= 1'b0;
                        depar_out_tlast <= 1'b0;
                        state <= S_IDLE;
                    end else if (payload_pop) begin
                        depar_out_tvalid <= 1'b1;
                        depar_out_tlast <= pkt_fifo_tlast;
                    end else if (out_fire) begin
                        // payload not yet in the fifo
                        depar_out_tvalid <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            beat_q <= pkt_fifo_tdata;
            keep_q <= pkt_fifo_tkeep;
            last_q <= pkt_fifo_tlast;
            lookup_addr <= pkt_fifo_tdata[TABLE_ADDR_LSB +: TABLE_ADDR_W];
            phv_stored <= phv_fifo_out;
        end
        if (state == S_APPLY) begin
            depar_out_tdata <= beat_applied;
            depar_out_tkeep <= keep_q;
        end else if (payload_pop) begin
            depar_out_tdata <= pkt_fifo_tdata;
            depar_out_tkeep <= pkt_fifo_tkeep;
        end
    end

    a_no_pkt_pop_empty: assert property (@(posedge clk) disable iff (!aresetn)
        !(pkt_fifo_rd_en && pkt_fifo_empty));

    a_no_phv_pop_empty: assert property (@(posedge clk) disable iff (!aresetn)
        !(phv_fifo_rd_en && phv_fifo_empty));

    a_out_stable: assert property (@(posedge clk) disable iff (!aresetn)
        depar_out_tvalid && !depar_out_tready |=> depar_out_tvalid
            && $stable(depar_out_tdata) && $stable(depar_out_tkeep)
            && $stable(depar_out_tlast));

endmodule

// File: src/deparser_top.sv
`timescale 1ns/1ps

module deparser_top #(
    parameter int DATA_WIDTH = 512,
    parameter int DEPARSER_ID = 5
) (
    input  logic                               clk,
    input  logic                               aresetn,

    input  logic [DATA_WIDTH-1:0]              pkt_fifo_tdata,
    input  logic [DATA_WIDTH/8-1:0]            pkt_fifo_tkeep,
    input  logic                               pkt_fifo_tlast,
    input  logic                               pkt_fifo_empty,
    output logic                               pkt_fifo_rd_en,

    input  logic [deparser_pkg::PHV_W-1:0]     phv_fifo_out,
    input  logic                               phv_fifo_empty,
    output logic                               phv_fifo_rd_en,

    output logic [DATA_WIDTH-1:0]              depar_out_tdata,
    output logic [DATA_WIDTH/8-1:0]            depar_out_tkeep,
    output logic                               depar_out_tlast,
    output logic                               depar_out_tvalid,
    input  logic                               depar_out_tready,

    input  logic [DATA_WIDTH-1:0]              c_s_axis_tdata,
    input  logic                               c_s_axis_tvalid,
    input  logic                               c_s_axis_tlast
);
    import deparser_pkg::*;

    logic [TABLE_ADDR_W-1:0]  lookup_addr;
    logic                     lookup_en;
    logic [ENTRY_W-1:0]       action_entry;
    logic [PHV_W-1:0]         phv_stored;
    logic                     fetch_en;
    logic [FIELD_VALUE_W-1:0] field_value [N_ACTIONS];
    logic [FIELD_BYTES_W-1:0] field_bytes [N_ACTIONS];
    logic [ACT_OFF_W-1:0]     field_offset [N_ACTIONS];

    action_table #(
        .DATA_WIDTH(DATA_WIDTH),
        .DEPARSER_ID(DEPARSER_ID)
    ) action_table_i (
        .clk(clk),
        .aresetn(aresetn),
        .c_s_axis_tdata(c_s_axis_tdata),
        .c_s_axis_tvalid(c_s_axis_tvalid),
        .c_s_axis_tlast(c_s_axis_tlast),
        .lookup_addr(lookup_addr),
        .lookup_en(lookup_en),
        .action_entry(action_entry)
    );

    for (genvar g = 0; g < N_ACTIONS; g++) begin : g_fetch
        container_fetch container_fetch_i (
            .clk(clk),
            .aresetn(aresetn),
            .phv(phv_stored),
            .action(action_entry[g*ACTION_W +: ACTION_W]),
            .fetch_en(fetch_en),
            .field_value(field_value[g]),
            .field_bytes(field_bytes[g]),
            .field_offset(field_offset[g])
        );
    end

    deparse_fsm #(
        .DATA_WIDTH(DATA_WIDTH)
    ) deparse_fsm_i (
        .clk(clk),
        .aresetn(aresetn),
        .pkt_fifo_tdata(pkt_fifo_tdata),
        .pkt_fifo_tkeep(pkt_fifo_tkeep),
        .pkt_fifo_tlast(pkt_fifo_tlast),
        .pkt_fifo_empty(pkt_fifo_empty),
        .pkt_fifo_rd_en(pkt_fifo_rd_en),
        .phv_fifo_out(phv_fifo_out),
        .phv_fifo_empty(phv_fifo_empty),
        .phv_fifo_rd_en(phv_fifo_rd_en),
        .field_value(field_value),
        .field_bytes(field_bytes),
        .field_offset(field_offset),
        .lookup_addr(lookup_addr),
        .lookup_en(lookup_en),
        .phv_stored(phv_stored),
        .fetch_en(fetch_en),
        .depar_out_tdata(depar_out_tdata),
        .depar_out_tkeep(depar_out_tkeep),
        .depar_out_tlast(depar_out_tlast),
        .depar_out_tvalid(depar_out_tvalid),
        .depar_out_tready(depar_out_tready)
    );

endmodule

// File: verif/tb_deparser.sv
`timescale 1ns/1ps

module tb_deparser;

    localparam int DATA_WIDTH = 512;
    localparam int BEAT_BYTES = DATA_WIDTH / 8;
    localparam int PHV_BITS = 768;
    localparam int ADDR_BIT = 120;
    localparam int MODID_BIT = 368;
    localparam int FLAG_BIT = 320;
    localparam int INDEX_BIT = 384;
    localparam int DRAIN_LIMIT = 2000;

    logic                  clk = 1'b0;
    logic                  aresetn;
    logic [DATA_WIDTH-1:0] pkt_fifo_tdata = '0;
    logic [BEAT_BYTES-1:0] pkt_fifo_tkeep = '0;
    logic                  pkt_fifo_tlast = 1'b0;
    logic                  pkt_fifo_empty = 1'b1;
    logic                  pkt_fifo_rd_en;
    logic [PHV_BITS-1:0]   phv_fifo_out = '0;
    logic                  phv_fifo_empty = 1'b1;
    logic                  phv_fifo_rd_en;
    logic [DATA_WIDTH-1:0] depar_out_tdata;
    logic [BEAT_BYTES-1:0] depar_out_tkeep;
    logic                  depar_out_tlast;
    logic                  depar_out_tvalid;
    logic                  depar_out_tready = 1'b0;
    logic [DATA_WIDTH-1:0] c_s_axis_tdata;
    logic                  c_s_axis_tvalid;
    logic                  c_s_axis_tlast;

    // fifo contents and expected output beats, oldest first
    logic [DATA_WIDTH-1:0] pkt_data_q [$];
    logic [BEAT_BYTES-1:0] pkt_keep_q [$];
    logic                  pkt_last_q [$];
    logic [PHV_BITS-1:0]   phv_q [$];
    logic [DATA_WIDTH-1:0] exp_data_q [$];
    logic [BEAT_BYTES-1:0] exp_keep_q [$];
    logic                  exp_last_q [$];

    integer                seed = 7174;
    int                    fd;
    int                    err_count = 0;
    int                    beat_count = 0;
    bit                    run_aborted;
    bit                    quiet_check = 1'b1;
    bit                    held_valid = 1'b0;
    logic [DATA_WIDTH-1:0] held_data;
    logic [BEAT_BYTES-1:0] held_keep;
    logic                  held_last;

    deparser_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .DEPARSER_ID(5)
    ) dut_i (
        .clk(clk),
        .aresetn(aresetn),
        .pkt_fifo_tdata(pkt_fifo_tdata),
        .pkt_fifo_tkeep(pkt_fifo_tkeep),
        .pkt_fifo_tlast(pkt_fifo_tlast),
        .pkt_fifo_empty(pkt_fifo_empty),
        .pkt_fifo_rd_en(pkt_fifo_rd_en),
        .phv_fifo_out(phv_fifo_out),
        .phv_fifo_empty(phv_fifo_empty),
        .phv_fifo_rd_en(phv_fifo_rd_en),
        .depar_out_tdata(depar_out_tdata),
        .depar_out_tkeep(depar_out_tkeep),
        .depar_out_tlast(depar_out_tlast),
        .depar_out_tvalid(depar_out_tvalid),
        .depar_out_tready(depar_out_tready),
        .c_s_axis_tdata(c_s_axis_tdata),
        .c_s_axis_tvalid(c_s_axis_tvalid),
        .c_s_axis_tlast(c_s_axis_tlast)
    );

    always #20 clk = ~clk;

    // byte i holds tag + i, table address patched into bits 120..123
    function automatic logic [DATA_WIDTH-1:0] make_beat(input logic [7:0] tag,
                                                        input logic [3:0] addr);
        logic [DATA_WIDTH-1:0] b;
        for (int i = 0; i < BEAT_BYTES; i++) begin
            b[i*8 +: 8] = tag + 8'(i);
        end
        b[ADDR_BIT +: 4] = addr;
        return b;
    endfunction

    function automatic logic [PHV_BITS-1:0] make_phv(input logic [7:0] tag);
        logic [PHV_BITS-1:0] p;
        for (int i = 0; i < PHV_BITS / 8; i++) begin
            p[i*8 +: 8] = tag + 8'(i);
        end
        return p;
    endfunction

    task automatic refresh_fifo_outputs();
        pkt_fifo_empty = (pkt_data_q.size() == 0);
        if (!pkt_fifo_empty) begin
            pkt_fifo_tdata = pkt_data_q[0];
            pkt_fifo_tkeep = pkt_keep_q[0];
            pkt_fifo_tlast = pkt_last_q[0];
        end
        phv_fifo_empty = (phv_q.size() == 0);
        if (!phv_fifo_empty) begin
            phv_fifo_out = phv_q[0];
        end
    endtask

    task automatic check_out_beat();
        if (exp_data_q.size() == 0) begin
            err_count++;
            $display("output beat arrived with no expected beat left");
        end else begin
            if (depar_out_tdata !== exp_data_q[0]) begin
                err_count++;
                $display("FAIL depar_out_tdata beat %0d expected %h actual %h",
                         beat_count, exp_data_q[0], depar_out_tdata);
            end
            if (depar_out_tkeep !== exp_keep_q[0]) begin
                err_count++;
                $display("FAIL depar_out_tkeep beat %0d expected %h actual %h",
                         beat_count, exp_keep_q[0], depar_out_tkeep);
            end
            if (depar_out_tlast !== exp_last_q[0]) begin
                err_count++;
                $display("FAIL depar_out_tlast beat %0d expected %h actual %h",
                         beat_count, exp_last_q[0], depar_out_tlast);
            end
            exp_data_q.delete(0);
            exp_keep_q.delete(0);
            exp_last_q.delete(0);
            beat_count++;
        end
    endtask

    // fifo models, output checker and random sink
    always @(posedge clk) begin
        if (!aresetn || quiet_check) begin
            if (depar_out_tvalid || pkt_fifo_rd_en || phv_fifo_rd_en) begin
                err_count++;
                $display("valid or fifo pop seen during or right after reset");
            end
        end
        if (aresetn) begin
            if (pkt_fifo_rd_en) begin
                if (pkt_fifo_empty) begin
                    err_count++;
                    $display("packet FIFO popped while empty");
                end else begin
                    pkt_data_q.delete(0);
                    pkt_keep_q.delete(0);
                    pkt_last_q.delete(0);
                end
            end
            if (phv_fifo_rd_en) begin
                if (phv_fifo_empty) begin
                    err_count++;
                    $display("PHV FIFO popped while empty");
                end else begin
                    phv_q.delete(0);
                end
            end
            if (held_valid) begin
                if (!depar_out_tvalid) begin
                    err_count++;
                    $display("depar_out_tvalid dropped while the sink stalled");
                end
                if (depar_out_tdata !== held_data) begin
                    err_count++;
                    $display("FAIL depar_out_tdata held %h actual %h", held_data, depar_out_tdata);
                end
                if (depar_out_tkeep !== held_keep || depar_out_tlast !== held_last) begin
                    err_count++;
                    $display("FAIL depar_out_tkeep/tlast held %h/%h actual %h/%h",
                             held_keep, held_last, depar_out_tkeep, depar_out_tlast);
                end
            end
            if (depar_out_tvalid && depar_out_tready) begin
                check_out_beat();
            end
        end
        held_valid = aresetn && depar_out_tvalid && !depar_out_tready;
        held_data = depar_out_tdata;
        held_keep = depar_out_tkeep;
        held_last = depar_out_tlast;
        #2;
        refresh_fifo_outputs();
        depar_out_tready = (($random(seed) & 3) != 0);
    end

    // one control beat, then an idle cycle
    task automatic send_ctrl(input logic [DATA_WIDTH-1:0] data, input logic last);
        #1;
        c_s_axis_tdata = data;
        c_s_axis_tvalid = 1'b1;
        c_s_axis_tlast = last;
        @(posedge clk);
        #2;
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((pkt_data_q.size() != 0 || phv_q.size() != 0 || exp_data_q.size() != 0)
               && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pkt_data_q.size() != 0 || phv_q.size() != 0 || exp_data_q.size() != 0) begin
            $display("timeout after %0d cycles waiting for queued traffic to drain", cycles);
            run_aborted = 1'b1;
        end
    endtask

    task automatic run_vectors();
        logic [7:0]            kind;
        logic [8*120-1:0]      skip_line;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [31:0]           c;
        logic [31:0]           d;
        logic [63:0]           keep;
        logic [47:0]           val;
        logic [DATA_WIDTH-1:0] beat;
        int                    code;
        bit                    done;
        done = 1'b0;
        while (!done && !run_aborted) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(skip_line, fd);
            end else if (kind == "H") begin
                code = $fscanf(fd, " %h %h %h", a, b, c);
                beat = '0;
                beat[MODID_BIT +: 8] = a[7:0];
                beat[FLAG_BIT +: 16] = b[15:0];
                beat[INDEX_BIT +: 8] = c[7:0];
                send_ctrl(beat, 1'b0);
            end else if (kind == "A") begin
                beat = '0;
                // action high byte goes first on the wire
                for (int k = 0; k < 5; k++) begin
                    code = $fscanf(fd, " %h", d);
                    beat[k*16 +: 8] = d[15:8];
                    beat[k*16+8 +: 8] = d[7:0];
                end
                code = $fscanf(fd, " %h", d);
                send_ctrl(beat, d[0]);
            end else if (kind == "V") begin
                code = $fscanf(fd, " %h", a);
                phv_q.push_back(make_phv(a[7:0]));
            end else if (kind == "P" || kind == "E") begin
                code = $fscanf(fd, " %h %h %h %h", a, b, keep, d);
                if (kind == "P") begin
                    pkt_data_q.push_back(make_beat(a[7:0], b[3:0]));
                    pkt_keep_q.push_back(keep);
                    pkt_last_q.push_back(d[0]);
                end else begin
                    exp_data_q.push_back(make_beat(a[7:0], b[3:0]));
                    exp_keep_q.push_back(keep);
                    exp_last_q.push_back(d[0]);
                end
            end else if (kind == "X") begin
                code = $fscanf(fd, " %d %d %h", a, b, val);
                beat = exp_data_q[exp_data_q.size()-1];
                for (int j = 0; j < int'(b); j++) begin
                    beat[(int'(a) + j)*8 +: 8] = val[(int'(b) - 1 - j)*8 +: 8];
                end
                exp_data_q[exp_data_q.size()-1] = beat;
            end else if (kind == "G") begin
                wait_drained();
            end else begin
                $display("unknown record type in vector file: %c", kind);
                run_aborted = 1'b1;
            end
        end
    endtask

    initial begin
        int total;
        aresetn = 1'b0;
        c_s_axis_tdata = '0;
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast = 1'b0;
        run_aborted = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        aresetn = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        quiet_check = 1'b0;
        fd = $fopen("verif/deparser_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/deparser_vectors.txt");
            run_aborted = 1'b1;
        end else begin
            run_vectors();
            $fclose(fd);
        end
        if (!run_aborted) begin
            wait_drained();
        end
        total = err_count + (run_aborted ? 1 : 0);
        $display("errors: %0d, beats checked: %0d", total, beat_count);
        if (total == 0 && beat_count > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verif/deparser_vectors.txt
# H modid flag index | A act0..act4 last | V phv_tag | P/E tag addr keep last (all hex)
# X offset(dec) nbytes(dec) value(hex, msb first) patches the last E | G waits for drain
H 5 f2f1 2
A 0113 02a5 0537 0f11 015b 0
A 0012 0205 0000 0000 0000 0
A 003f 0000 0000 0000 0000 1
V 40
P 00 2 ffffffffffffffff 0
P 80 0 ffffffffffffffff 0
P c0 0 000000000000ffff 1
E 00 2 ffffffffffffffff 0
X 4 3 434b4a
X 10 4 5b5a5958
X 20 6 878685848382
X 60 2 4140
E 80 0 ffffffffffffffff 0
E c0 0 000000000000ffff 1
V 10
P 55 4 00000000ffffffff 1
E 55 4 00000000ffffffff 1
X 0 6 6f6e6d6c6b6a
V 20
P 33 3 ffffffffffffffff 0
P 99 0 00000000000000ff 1
E 33 3 ffffffffffffffff 0
E 99 0 00000000000000ff 1
G
H 4 f2f1 4
A 0113 0000 0000 0000 0000 1
H 5 f2f0 4
A 0113 0000 0000 0000 0000 1
V 30
P 12 4 ffffffffffffffff 1
E 12 4 ffffffffffffffff 1
X 0 6 8f8e8d8c8b8a
G

// File: project.f
src/deparser_pkg.sv
src/action_table.sv
src/container_fetch.sv
src/deparse_fsm.sv
src/deparser_top.sv
verif/tb_deparser.sv

// File: Makefile
TOP := tb_deparser

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
